// File: rtl/add_unit.sv
//////////////////////////////////////////////////
// Adder unit
// Registered add, subtract and set-less-than
//////////////////////////////////////////////////

`timescale 1ns/1ps

module add_unit (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  exec_pkg::op_t              op_i,        // OP_NONE when not selected
    input  logic [exec_pkg::XLEN-1:0]  a_i,
    input  logic [exec_pkg::XLEN-1:0]  b_i,
    output logic [exec_pkg::XLEN-1:0]  result_o     // Valid one cycle after issue
);

    import exec_pkg::*;

    logic lt_signed;                                // a < b as two's complement
    logic lt_unsigned;                              // a < b as magnitudes

    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else begin
            case (op_i)
                OP_ADD:  result_o <= a_i + b_i;
                OP_SUB:  result_o <= a_i - b_i;
                OP_SLT:  result_o <= {{(XLEN-1){1'b0}}, lt_signed};
                OP_SLTU: result_o <= {{(XLEN-1){1'b0}}, lt_unsigned};
                default: result_o <= '0;            // Idle or foreign op
            endcase
        end
    end

endmodule

// File: rtl/branch_unit.sv
//////////////////////////////////////////////////
// Branch unit
// Registered condition check, jump target
// and link value
//////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_unit (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  exec_pkg::op_t              op_i,
    input  logic [exec_pkg::XLEN-1:0]  a_i,         // Compare lhs or JALR base
    input  logic [exec_pkg::XLEN-1:0]  b_i,         // Compare rhs
    input  logic [exec_pkg::XLEN-1:0]  offset_i,    // Branch or jump offset
    input  logic [exec_pkg::XLEN-1:0]  npc_i,       // Next sequential PC
    output logic [exec_pkg::XLEN-1:0]  link_o,
    output logic [exec_pkg::XLEN-1:0]  target_o,
    output logic                       jump_o,      // Taken branch or jump
    output logic                       we_o         // Link goes to regbank
);

    import exec_pkg::*;

    logic            taken;                         // Condition of a branch
    logic [XLEN-1:0] link_d;
    logic [XLEN-1:0] target_d;
    logic            jump_d;
    logic            we_d;

    always_comb begin
        case (op_i)
            OP_BEQ:  taken = (a_i == b_i);
            OP_BNE:  taken = (a_i != b_i);
            OP_BLT:  taken = ($signed(a_i) <  $signed(b_i));
            OP_BGE:  taken = ($signed(a_i) >= $signed(b_i));
            OP_BLTU: taken = (a_i <  b_i);
            OP_BGEU: taken = (a_i >= b_i);
            default: taken = 1'b0;
        endcase
    end

    // Next values stay zero unless a branch op is present
    always_comb begin
        link_d   = '0;
        target_d = '0;
        jump_d   = 1'b0;
        we_d     = 1'b0;
        case (op_i)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                link_d   = npc_i;
                target_d = npc_i + offset_i;        // PC relative
                jump_d   = taken;
            end
            OP_JAL: begin
                link_d   = npc_i;
                target_d = npc_i + offset_i;
                jump_d   = 1'b1;
                we_d     = 1'b1;                    // Write return address
            end
            OP_JALR: begin
                link_d   = npc_i;
                target_d = (a_i + offset_i) & ~{{(XLEN-1){1'b0}}, 1'b1};  // Bit 0 cleared
                jump_d   = 1'b1;
                we_d     = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            link_o   <= '0;
            target_o <= '0;
            jump_o   <= 1'b0;
            we_o     <= 1'b0;
        end else begin
            link_o   <= link_d;
            target_o <= target_d;
            jump_o   <= jump_d;
            we_o     <= we_d;
        end
    end

endmodule

// File: rtl/exec_pkg.sv
//////////////////////////////////////////////////
// Execute stage shared definitions
// Operation and unit-select encodings, store
// size codes and the load data word view
//////////////////////////////////////////////////

package exec_pkg;

    localparam int XLEN  = 32;                 // Data word width
    localparam int TAG_W = 4;                  // Instruction tag width

    //////////////////////////////////////////////////
    // Operation encoding
    //////////////////////////////////////////////////
    typedef enum logic [4:0] {
        OP_NONE,                               // No operation so the unit idles
        OP_ADD,                                // Adder unit
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,                                // Logic unit
        OP_OR,
        OP_XOR,
        OP_SLL,                                // Shift unit
        OP_SRL,
        OP_SRA,
        OP_BEQ,                                // Branch unit conditionals
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,                                // Branch unit jumps with link
        OP_JALR,
        OP_LB,                                 // Memory unit loads
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,                                 // Memory unit stores
        OP_SH,
        OP_SW
    } op_t;

    //////////////////////////////////////////////////
    // Execute unit select
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        XU_NONE,                               // Bubble
        XU_ADD,
        XU_LOGIC,
        XU_SHIFT,
        XU_BRANCH,
        XU_MEM,
        XU_BYPASS                              // Operand B straight to result
    } xu_t;

    // Store size codes on the retire strobe
    localparam logic [1:0] SIZE_NONE = 2'd0;
    localparam logic [1:0] SIZE_BYTE = 2'd1;
    localparam logic [1:0] SIZE_HALF = 2'd2;
    localparam logic [1:0] SIZE_WORD = 2'd3;

    // Memory read data as a whole word or byte lanes
    typedef union packed {
        logic [XLEN-1:0]            word;      // Full word view
        logic [XLEN/8-1:0][7:0]     lane;      // Lane 0 is the lowest byte
    } load_word_u;

endpackage

// File: rtl/execute.sv
//////////////////////////////////////////////////
// Execute stage top level
// Steers operands to one unit, registers the
// unit select and picks the stage-2 outputs
//////////////////////////////////////////////////

`timescale 1ns/1ps

module execute (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic [exec_pkg::XLEN-1:0]   npc_i,
    input  logic [exec_pkg::XLEN-1:0]   op_a_i,
    input  logic [exec_pkg::XLEN-1:0]   op_b_i,
    input  logic [exec_pkg::XLEN-1:0]   op_c_i,        // Offset or store data
    input  exec_pkg::op_t               op_i,
    input  exec_pkg::xu_t               xu_sel_i,      // One unit per issue
    input  logic [exec_pkg::TAG_W-1:0]  tag_i,
    input  logic [exec_pkg::XLEN-1:0]   data_i,        // Data memory read data
    output logic [exec_pkg::XLEN-1:0]   result_0_o,
    output logic [exec_pkg::XLEN-1:0]   result_1_o,
    output logic                        jump_o,
    output logic [exec_pkg::TAG_W-1:0]  tag_o,
    output logic                        we_o,
    output logic [exec_pkg::XLEN-1:0]   read_address_o,
    output logic                        read_o,
    output logic                        write_o,
    output logic [1:0]                  size_o
);

    import exec_pkg::*;

    // Gated unit inputs
    op_t             add_op, logic_op, shift_op, br_op, mem_op;
    logic [XLEN-1:0] add_a, add_b, logic_a, logic_b, shift_a, shift_b;
    logic [XLEN-1:0] br_a, br_b, br_off, br_npc;
    logic [XLEN-1:0] mem_a, mem_b, mem_sd;

    // Unit results
    logic [XLEN-1:0] add_res, logic_res, shift_res;
    logic [XLEN-1:0] br_link, br_target, mem_data, mem_addr;
    logic            br_jump, br_we, mem_write, mem_we;
    logic [1:0]      mem_size;

    logic [XLEN-1:0] bypass_q;                         // Operand B one cycle late
    xu_t             xu_q;                             // Unit of the stage-2 op

    //////////////////////////////////////////////////
    // Dispatch
    //////////////////////////////////////////////////
    always_comb begin
        add_op   = OP_NONE;
        add_a    = '0;
        add_b    = '0;
        logic_op = OP_NONE;
        logic_a  = '0;
        logic_b  = '0;
        shift_op = OP_NONE;
        shift_a  = '0;
        shift_b  = '0;
        br_op    = OP_NONE;
        br_a     = '0;
        br_b     = '0;
        br_off   = '0;
        br_npc   = '0;
        mem_op   = OP_NONE;
        mem_a    = '0;
        mem_b    = '0;
        mem_sd   = '0;
        case (xu_sel_i)
            XU_ADD: begin
                add_op = op_i;
                add_a  = op_a_i;
                add_b  = op_b_i;
            end
            XU_LOGIC: begin
                logic_op = op_i;
                logic_a  = op_a_i;
                logic_b  = op_b_i;
            end
            XU_SHIFT: begin
                shift_op = op_i;
                shift_a  = op_a_i;
                shift_b  = op_b_i;
            end
            XU_BRANCH: begin
                br_op  = op_i;
                br_a   = op_a_i;
                br_b   = op_b_i;
                br_off = op_c_i;
                br_npc = npc_i;
            end
            XU_MEM: begin
                mem_op = op_i;
                mem_a  = op_a_i;
                mem_b  = op_b_i;
                mem_sd = op_c_i;                       // Store data
            end
            default: ;                                 // Bypass and bubble
        endcase
    end

    add_unit i_add (
        .clk(clk), .arst_n_i(arst_n_i), .op_i(add_op),
        .a_i(add_a), .b_i(add_b), .result_o(add_res)
    );

    logic_unit i_logic (
        .clk(clk), .arst_n_i(arst_n_i), .op_i(logic_op),
        .a_i(logic_a), .b_i(logic_b), .result_o(logic_res)
    );

    shift_unit i_shift (
        .clk(clk), .arst_n_i(arst_n_i), .op_i(shift_op),
        .a_i(shift_a), .b_i(shift_b), .result_o(shift_res)
    );

    branch_unit i_branch (
        .clk(clk), .arst_n_i(arst_n_i), .op_i(br_op),
        .a_i(br_a), .b_i(br_b), .offset_i(br_off), .npc_i(br_npc),
        .link_o(br_link), .target_o(br_target), .jump_o(br_jump), .we_o(br_we)
    );

    mem_unit i_mem (
        .clk(clk), .arst_n_i(arst_n_i), .op_i(mem_op),
        .a_i(mem_a), .b_i(mem_b), .store_data_i(mem_sd), .data_i(data_i),
        .read_o(read_o), .read_address_o(read_address_o),
        .data_o(mem_data), .address_o(mem_addr), .write_o(mem_write),
        .size_o(mem_size), .we_o(mem_we)
    );

    //////////////////////////////////////////////////
    // Bypass and stage-2 registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bypass_q <= '0;
            xu_q     <= XU_NONE;
            tag_o    <= '0;
        end else begin
            bypass_q <= (xu_sel_i == XU_BYPASS) ? op_b_i : '0;
            xu_q     <= xu_sel_i;
            tag_o    <= tag_i;
        end
    end

    // Output select on the stage-2 unit
    always_comb begin
        result_0_o = '0;
        result_1_o = '0;
        jump_o     = 1'b0;
        we_o       = 1'b0;
        write_o    = 1'b0;
        size_o     = SIZE_NONE;
        case (xu_q)
            XU_ADD: begin
                result_0_o = add_res;
                we_o       = 1'b1;
            end
            XU_LOGIC: begin
                result_0_o = logic_res;
                we_o       = 1'b1;
            end
            XU_SHIFT: begin
                result_0_o = shift_res;
                we_o       = 1'b1;
            end
            XU_BYPASS: begin
                result_0_o = bypass_q;
                we_o       = 1'b1;
            end
            XU_BRANCH: begin
                result_0_o = br_link;
                result_1_o = br_target;
                jump_o     = br_jump;
                we_o       = br_we;
            end
            XU_MEM: begin
                result_0_o = mem_data;
                result_1_o = mem_addr;
                we_o       = mem_we;
                write_o    = mem_write;
                size_o     = mem_size;
            end
            default: ;                                 // Bubble leaves all zero
        endcase
    end

endmodule

// File: rtl/logic_unit.sv
//////////////////////////////////////////////////
// Logic unit
// Registered bitwise and, or and xor
//////////////////////////////////////////////////

`timescale 1ns/1ps

module logic_unit (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  exec_pkg::op_t              op_i,
    input  logic [exec_pkg::XLEN-1:0]  a_i,
    input  logic [exec_pkg::XLEN-1:0]  b_i,
    output logic [exec_pkg::XLEN-1:0]  result_o     // Registered result
);

    import exec_pkg::*;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else begin
            case (op_i)
                OP_AND:  result_o <= a_i & b_i;
                OP_OR:   result_o <= a_i | b_i;
                OP_XOR:  result_o <= a_i ^ b_i;
                default: result_o <= '0;            // Not a logic op
            endcase
        end
    end

endmodule

// File: rtl/mem_unit.sv
//////////////////////////////////////////////////
// Memory unit
// Address generation, load extraction from the
// data port and store retirement strobe
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_unit (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  exec_pkg::op_t              op_i,
    input  logic [exec_pkg::XLEN-1:0]  a_i,           // Base
    input  logic [exec_pkg::XLEN-1:0]  b_i,           // Displacement
    input  logic [exec_pkg::XLEN-1:0]  store_data_i,
    input  logic [exec_pkg::XLEN-1:0]  data_i,        // Read data in the same cycle
    output logic                       read_o,        // Combinational in the issue cycle
    output logic [exec_pkg::XLEN-1:0]  read_address_o,
    output logic [exec_pkg::XLEN-1:0]  data_o,        // Load result or store data
    output logic [exec_pkg::XLEN-1:0]  address_o,     // Access address
    output logic                       write_o,       // Store retire strobe
    output logic [1:0]                 size_o,
    output logic                       we_o           // Load goes to regbank
);

    import exec_pkg::*;

    logic [XLEN-1:0] addr;
    logic            is_load;
    logic            is_store;
    load_word_u      ld;                              // Read word split in lanes
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] load_data;                       // Extended load value
    logic [1:0]      st_size;

    assign addr     = a_i + b_i;
    assign is_load  = op_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    assign is_store = op_i inside {OP_SB, OP_SH, OP_SW};

    assign read_o         = is_load;
    assign read_address_o = is_load ? addr : '0;

    //////////////////////////////////////////////////
    // Load lane select and extension
    //////////////////////////////////////////////////
    assign ld      = data_i;
    assign ld_byte = ld.lane[addr[1:0]];
    assign ld_half = {ld.lane[{addr[1], 1'b1}], ld.lane[{addr[1], 1'b0}]};  // Aligned half

    always_comb begin
        case (op_i)
            OP_LB:   load_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            OP_LBU:  load_data = {{(XLEN-8){1'b0}}, ld_byte};
            OP_LH:   load_data = {{(XLEN-16){ld_half[15]}}, ld_half};
            OP_LHU:  load_data = {{(XLEN-16){1'b0}}, ld_half};
            OP_LW:   load_data = ld.word;
            default: load_data = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_SB:   st_size = SIZE_BYTE;
            OP_SH:   st_size = SIZE_HALF;
            OP_SW:   st_size = SIZE_WORD;
            default: st_size = SIZE_NONE;
        endcase
    end

    //////////////////////////////////////////////////
    // Result registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_o    <= '0;
            address_o <= '0;
            write_o   <= 1'b0;
            size_o    <= SIZE_NONE;
            we_o      <= 1'b0;
        end else begin
            data_o    <= is_store ? store_data_i : load_data;
            address_o <= (is_load || is_store) ? addr : '0;
            write_o   <= is_store;
            size_o    <= st_size;
            we_o      <= is_load;
        end
    end

endmodule

// File: rtl/shift_unit.sv
//////////////////////////////////////////////////
// Shift unit
// Registered logical and arithmetic shifts
//////////////////////////////////////////////////

`timescale 1ns/1ps

module shift_unit (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  exec_pkg::op_t              op_i,
    input  logic [exec_pkg::XLEN-1:0]  a_i,         // Value to shift
    input  logic [exec_pkg::XLEN-1:0]  b_i,         // Amount in low 5 bits
    output logic [exec_pkg::XLEN-1:0]  result_o
);

    import exec_pkg::*;

    logic [4:0] shamt;                              // Upper bits of b ignored

    assign shamt = b_i[4:0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else begin
            case (op_i)
                OP_SLL:  result_o <= a_i << shamt;
                OP_SRL:  result_o <= a_i >> shamt;             // Zero fill
                OP_SRA:  result_o <= $signed(a_i) >>> shamt;   // Sign fill
                default: result_o <= '0;
            endcase
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_execute \
    -Mdir obj_dir -o tb_execute_sim

./obj_dir/tb_execute_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: tb/tb_execute.sv
//////////////////////////////////////////////////
// Execute stage testbench
// Random issue stream checked against a model
// and a 256-word data memory model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_execute;

    import exec_pkg::*;

    localparam int CLK_PERIOD  = 20;                    // ns
    localparam int RST_CYCLES  = 16;
    localparam int N_OPS       = 2000;                  // Random issues
    localparam int TIMEOUT_CYC = RST_CYCLES + N_OPS + 20;

    logic              clk = 1'b0;
    logic              arst_n_i;
    logic [XLEN-1:0]   npc_i, op_a_i, op_b_i, op_c_i, data_i;
    op_t               op_i;
    xu_t               xu_sel_i;
    logic [TAG_W-1:0]  tag_i;
    logic [XLEN-1:0]   result_0_o, result_1_o, read_address_o;
    logic              jump_o, we_o, read_o, write_o;
    logic [TAG_W-1:0]  tag_o;
    logic [1:0]        size_o;

    logic [XLEN-1:0]   mem [0:255];                     // Data memory model
    logic [XLEN-1:0]   exp_r0, exp_r1, exp_raddr;       // Model of the op in flight
    logic              exp_jump, exp_we, exp_write, exp_read;
    logic [1:0]        exp_size;
    logic [TAG_W-1:0]  exp_tag;
    int                error_count = 0;
    int                check_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign data_i = mem[read_address_o[9:2]];           // Combinational read

    execute i_dut (
        .clk(clk), .arst_n_i(arst_n_i), .npc_i(npc_i),
        .op_a_i(op_a_i), .op_b_i(op_b_i), .op_c_i(op_c_i), .op_i(op_i),
        .xu_sel_i(xu_sel_i), .tag_i(tag_i), .data_i(data_i),
        .result_0_o(result_0_o), .result_1_o(result_1_o), .jump_o(jump_o),
        .tag_o(tag_o), .we_o(we_o), .read_address_o(read_address_o),
        .read_o(read_o), .write_o(write_o), .size_o(size_o)
    );

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic drive_idle();
        xu_sel_i = XU_NONE;
        op_i     = OP_NONE;
        op_a_i   = '0;
        op_b_i   = '0;
        op_c_i   = '0;
        npc_i    = '0;
        tag_i    = '0;
    endtask

    task automatic drive_issue();
        xu_t             xu;
        logic [XLEN-1:0] a, b, addr;
        xu   = xu_t'($urandom_range(0, 6));
        a    = $urandom;
        b    = $urandom;
        op_i = OP_NONE;                                 // Bypass and bubble
        case (xu)
            XU_ADD:    op_i = op_t'(OP_ADD + $urandom_range(0, 3));
            XU_LOGIC:  op_i = op_t'(OP_AND + $urandom_range(0, 2));
            XU_SHIFT:  op_i = op_t'(OP_SLL + $urandom_range(0, 2));
            XU_BRANCH: begin
                op_i = op_t'(OP_BEQ + $urandom_range(0, 7));
                if ($urandom_range(0, 3) == 0) b = a;   // Equal operands now and then
            end
            XU_MEM: begin
                op_i = op_t'(OP_LB + $urandom_range(0, 7));
                a    = a & 32'h0000_03FF;               // Stay inside 1 KiB
                b    = b & 32'h0000_001F;
                addr = a + b;
                if (op_i inside {OP_LH, OP_LHU, OP_SH}) b = b - (addr & 32'd1);
                else if (op_i inside {OP_LW, OP_SW}) b = b - (addr & 32'd3);
            end
            default: ;
        endcase
        xu_sel_i = xu;
        op_a_i   = a;
        op_b_i   = b;
        op_c_i   = $urandom;                            // Offset or store data
        npc_i    = $urandom & 32'hFFFF_FFFC;
        tag_i    = 4'($urandom_range(0, 15));
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    task automatic predict_issue();
        logic [XLEN-1:0] addr;
        load_word_u      w;
        logic [15:0]     half;
        logic [7:0]      lane_b;
        exp_r0    = '0;
        exp_r1    = '0;
        exp_jump  = 1'b0;
        exp_we    = 1'b0;
        exp_write = 1'b0;
        exp_size  = SIZE_NONE;
        exp_read  = 1'b0;
        exp_raddr = '0;
        exp_tag   = tag_i;
        addr      = op_a_i + op_b_i;
        case (xu_sel_i)
            XU_ADD, XU_LOGIC, XU_SHIFT, XU_BYPASS: begin
                exp_we = 1'b1;
                case (op_i)
                    OP_ADD:  exp_r0 = op_a_i + op_b_i;
                    OP_SUB:  exp_r0 = op_a_i - op_b_i;
                    OP_SLT:  exp_r0 = ($signed(op_a_i) < $signed(op_b_i)) ? 32'd1 : 32'd0;
                    OP_SLTU: exp_r0 = (op_a_i < op_b_i) ? 32'd1 : 32'd0;
                    OP_AND:  exp_r0 = op_a_i & op_b_i;
                    OP_OR:   exp_r0 = op_a_i | op_b_i;
                    OP_XOR:  exp_r0 = op_a_i ^ op_b_i;
                    OP_SLL:  exp_r0 = op_a_i << op_b_i[4:0];
                    OP_SRL:  exp_r0 = op_a_i >> op_b_i[4:0];
                    OP_SRA:  exp_r0 = $signed(op_a_i) >>> op_b_i[4:0];
                    default: exp_r0 = op_b_i;           // Bypass passes B
                endcase
            end
            XU_BRANCH: begin
                exp_r0 = npc_i;                         // Link
                exp_r1 = npc_i + op_c_i;
                case (op_i)
                    OP_BEQ:  exp_jump = (op_a_i == op_b_i);
                    OP_BNE:  exp_jump = (op_a_i != op_b_i);
                    OP_BLT:  exp_jump = ($signed(op_a_i) < $signed(op_b_i));
                    OP_BGE:  exp_jump = !($signed(op_a_i) < $signed(op_b_i));
                    OP_BLTU: exp_jump = (op_a_i < op_b_i);
                    OP_BGEU: exp_jump = !(op_a_i < op_b_i);
                    default: begin                      // JAL and JALR
                        exp_jump = 1'b1;
                        exp_we   = 1'b1;
                        if (op_i == OP_JALR) exp_r1 = {op_a_i[31:1] + op_c_i[31:1]
                            + 31'(op_a_i[0] & op_c_i[0]), 1'b0};
                    end
                endcase
            end
            XU_MEM: begin
                exp_r1 = addr;
                if (op_i inside {OP_SB, OP_SH, OP_SW}) begin
                    exp_r0    = op_c_i;
                    exp_write = 1'b1;
                    exp_size  = (op_i == OP_SB) ? SIZE_BYTE :
                                (op_i == OP_SH) ? SIZE_HALF : SIZE_WORD;
                end else begin
                    exp_read  = 1'b1;
                    exp_raddr = addr;
                    exp_we    = 1'b1;
                    w.word    = mem[addr[9:2]];
                    lane_b    = w.lane[addr[1:0]];
                    half      = addr[1] ? w.word[31:16] : w.word[15:0];
                    case (op_i)
                        OP_LB:   exp_r0 = {{24{lane_b[7]}}, lane_b};
                        OP_LBU:  exp_r0 = {24'd0, lane_b};
                        OP_LH:   exp_r0 = {{16{half[15]}}, half};
                        OP_LHU:  exp_r0 = {16'd0, half};
                        default: exp_r0 = w.word;
                    endcase
                end
            end
            default: ;                                  // Bubble gives zeros
        endcase
    endtask

    task automatic retire_store();
        load_word_u w;
        w.word = mem[exp_r1[9:2]];
        case (exp_size)
            SIZE_BYTE: w.lane[exp_r1[1:0]] = exp_r0[7:0];
            SIZE_HALF: begin
                w.lane[{exp_r1[1], 1'b0}] = exp_r0[7:0];
                w.lane[{exp_r1[1], 1'b1}] = exp_r0[15:8];
            end
            default:   w.word = exp_r0;
        endcase
        mem[exp_r1[9:2]] = w.word;                      // Seen by later loads
    endtask

    task automatic check_stage2();
        compare_word("result_0_o", exp_r0, result_0_o);
        compare_word("result_1_o", exp_r1, result_1_o);
        compare_word("jump_o", 32'(exp_jump), 32'(jump_o));
        compare_word("we_o", 32'(exp_we), 32'(we_o));
        compare_word("write_o", 32'(exp_write), 32'(write_o));
        compare_word("size_o", 32'(exp_size), 32'(size_o));
        compare_word("tag_o", 32'(exp_tag), 32'(tag_o));
    endtask

    task automatic check_read_port();
        compare_word("read_o", 32'(exp_read), 32'(read_o));
        if (exp_read) compare_word("read_address_o", exp_raddr, read_address_o);
    endtask

    //////////////////////////////////////////////////
    // Stimulus and checking
    //////////////////////////////////////////////////
    initial begin
        int         i;
        logic [7:0] k;
        void'($urandom(18));
        for (i = 0; i < 256; i++) begin
            k      = 8'(i);
            mem[i] = {k, ~k, k ^ 8'h5A, k + 8'h3C};    // Unique per address
        end
        drive_idle();
        arst_n_i  = 1'b0;
        exp_r0    = '0;
        exp_r1    = '0;
        exp_raddr = '0;
        exp_jump  = 1'b0;
        exp_we    = 1'b0;
        exp_write = 1'b0;
        exp_read  = 1'b0;
        exp_size  = SIZE_NONE;
        exp_tag   = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #2 arst_n_i = 1'b1;
        #17;
        check_stage2();                                 // Reset values
        check_read_port();
        for (i = 0; i <= N_OPS; i++) begin
            @(posedge clk);
            #2;
            if (i < N_OPS) drive_issue();
            else drive_idle();                          // Drain last op
            #17;                                        // Just before next edge
            check_stage2();
            if (exp_write) retire_store();
            predict_issue();
            check_read_port();
        end
        $display("Run finished with %0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("Timeout: simulation did not finish in %0d cycles", TIMEOUT_CYC);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: vlog.f
rtl/exec_pkg.sv
rtl/add_unit.sv
rtl/logic_unit.sv
rtl/shift_unit.sv
rtl/branch_unit.sv
rtl/mem_unit.sv
rtl/execute.sv
tb/tb_execute.sv
